/* verilog/rob_macros.svh */
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// number of in-flight entries
`define ROB_DEPTH 8

// entry tag and head/tail pointer width
`define ROB_IDX_W 3

// occupancy count, must reach ROB_DEPTH
`define ROB_CNT_W 4

// architectural register index
`define REG_IDX_W 5

`endif

/* verilog/rob_pkg.sv */
package rob_pkg;

    // operation class kept per entry
    typedef enum logic [1:0] {
        op_alu = 2'd0,
        op_ld  = 2'd1,
        op_st  = 2'd2,
        op_br  = 2'd3
    } rob_op_t;

    // commit sequencer states
    // mem_req / mem_release are the two halves of the cache handshake
    typedef enum logic [1:0] {
        cs_idle        = 2'd0,
        cs_mem_req     = 2'd1,
        cs_mem_release = 2'd2,
        cs_flush       = 2'd3
    } commit_state_t;

endpackage

/* verilog/rob_ptr_ctrl.sv */
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_ptr_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  alloc_req,
    input  logic                  retire,
    input  logic                  flush_clear,
    output logic [`ROB_IDX_W-1:0] head_idx,
    output logic [`ROB_IDX_W-1:0] tail_idx,
    output logic                  alloc_we,
    output logic                  rob_full
);

    logic [`ROB_CNT_W-1:0] count_q;
    logic [`ROB_IDX_W-1:0] head_next;

    // pointer increment with explicit wrap at depth
    function automatic logic [`ROB_IDX_W-1:0] wrap_inc(input logic [`ROB_IDX_W-1:0] idx);
        logic [`ROB_IDX_W-1:0] nxt;
        if (idx == `ROB_IDX_W'(`ROB_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = idx + 1'b1;
        end
        return nxt;
    endfunction

    assign head_next = wrap_inc(head_idx);

    // no new entries while the flush rewinds the tail
    assign rob_full = (count_q == `ROB_CNT_W'(`ROB_DEPTH)) || flush_clear;
    assign alloc_we = alloc_req && !rob_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_idx <= '0;
            tail_idx <= '0;
            count_q  <= '0;
        end else if (flush_clear) begin
            // branch at head retires, everything younger is gone
            head_idx <= head_next;
            tail_idx <= head_next;
            count_q  <= '0;
        end else begin
            if (retire) begin
                head_idx <= head_next;
            end
            if (alloc_we) begin
                tail_idx <= wrap_inc(tail_idx);
            end
            case ({alloc_we, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                // both or neither, occupancy unchanged
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* verilog/rob_entry_array.sv */
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_entry_array (
    input  logic                  clk,
    input  logic                  rst,
    // write port at the tail
    input  logic                  alloc_we,
    input  logic [`ROB_IDX_W-1:0] alloc_idx,
    input  rob_pkg::rob_op_t      alloc_op,
    input  logic [`REG_IDX_W-1:0] alloc_rd,
    input  logic                  alloc_pred_taken,
    // out-of-order completion by tag
    input  logic                  done_valid,
    input  logic [`ROB_IDX_W-1:0] done_tag,
    input  logic                  done_br_taken,
    // head side, steered by pointer block and FSM
    input  logic [`ROB_IDX_W-1:0] head_idx,
    input  logic                  retire,
    input  logic                  flush_clear,
    output rob_pkg::rob_op_t      head_op,
    output logic [`REG_IDX_W-1:0] head_rd,
    output logic                  head_done,
    output logic                  head_mispredict
);
    import rob_pkg::*;

    // per-entry payload
    rob_op_t               op_q   [`ROB_DEPTH];
    // dest reg, or data source reg for stores
    logic [`REG_IDX_W-1:0] rd_q   [`ROB_DEPTH];
    // predicted direction, branches only
    logic                  pred_q [`ROB_DEPTH];
    // resolved direction, branches only
    logic                  res_q  [`ROB_DEPTH];

    // completion flags, one per entry
    logic [`ROB_DEPTH-1:0] done_q;

    logic                  done_is_br;

    // completion only carries a direction for branches
    assign done_is_br = (op_q[done_tag] == op_br);

    always_ff @(posedge clk) begin
        if (alloc_we) begin
            op_q[alloc_idx]   <= alloc_op;
            rd_q[alloc_idx]   <= alloc_rd;
            pred_q[alloc_idx] <= alloc_pred_taken;
            // unresolved branch reads as correctly predicted
            res_q[alloc_idx]  <= alloc_pred_taken;
        end
        if (done_valid && done_is_br) begin
            res_q[done_tag] <= done_br_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= '0;
        end else if (flush_clear) begin
            // younger entries are discarded
            // drop any completions they already got
            done_q <= '0;
        end else begin
            // fresh entry starts not done
            if (alloc_we) begin
                done_q[alloc_idx] <= 1'b0;
            end
            if (done_valid) begin
                done_q[done_tag] <= 1'b1;
            end
            // head leaves the buffer
            if (retire) begin
                done_q[head_idx] <= 1'b0;
            end
        end
    end

    // head readout, no latency
    assign head_op   = op_q[head_idx];
    assign head_rd   = rd_q[head_idx];
    assign head_done = done_q[head_idx];

    // only meaningful for a branch at the head
    assign head_mispredict = (op_q[head_idx] == op_br) &&
                             (pred_q[head_idx] != res_q[head_idx]);

endmodule

/* verilog/rob_commit_fsm.sv */
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_commit_fsm (
    input  logic                  clk,
    input  logic                  rst,
    // head entry view
    input  rob_pkg::rob_op_t      head_op,
    input  logic [`REG_IDX_W-1:0] head_rd,
    input  logic                  head_done,
    input  logic                  head_mispredict,
    // data cache acknowledge
    input  logic                  mem_ack,
    // to pointer block and entry array
    output logic                  retire,
    output logic                  flush_clear,
    // register commit
    output logic                  reg_write,
    output logic [`REG_IDX_W-1:0] commit_rd,
    output logic                  ld_commit_sel,
    // data cache request
    output logic                  mem_req,
    output logic                  mem_write,
    output logic [`REG_IDX_W-1:0] mem_reg,
    // fetch redirect
    output logic                  pc_redirect
);
    import rob_pkg::*;

    commit_state_t state_q;

    // head is ready and not the one already retiring this cycle
    logic          head_go;
    // second half of the handshake seen, memory op may retire
    logic          mem_done;

    // retire is high during the pulse cycle, head still points at the old entry
    assign head_go  = (state_q == cs_idle) && head_done && !retire;
    assign mem_done = (state_q == cs_mem_release) && !mem_ack;

    // register index copies, captured when the head is taken up
    always_ff @(posedge clk) begin
        if (head_go) begin
            commit_rd <= head_rd;
            mem_reg   <= head_rd;
            mem_write <= (head_op == op_st);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= cs_idle;
            retire        <= 1'b0;
            flush_clear   <= 1'b0;
            reg_write     <= 1'b0;
            ld_commit_sel <= 1'b0;
            mem_req       <= 1'b0;
            pc_redirect   <= 1'b0;
        end else begin
            // pulses last one cycle
            retire        <= 1'b0;
            flush_clear   <= 1'b0;
            reg_write     <= 1'b0;
            ld_commit_sel <= 1'b0;
            pc_redirect   <= 1'b0;

            case (state_q)
                cs_idle: begin
                    if (head_go) begin
                        case (head_op)
                            op_alu: begin
                                retire    <= 1'b1;
                                reg_write <= 1'b1;
                            end
                            op_ld, op_st: begin
                                // open the four-phase exchange
                                state_q <= cs_mem_req;
                                mem_req <= 1'b1;
                            end
                            op_br: begin
                                if (head_mispredict) begin
                                    state_q     <= cs_flush;
                                    flush_clear <= 1'b1;
                                    pc_redirect <= 1'b1;
                                end else begin
                                    // correct prediction, silent retire
                                    retire <= 1'b1;
                                end
                            end
                            default: state_q <= cs_idle;
                        endcase
                    end
                end
                cs_mem_req: begin
                    // cache took the request, release it
                    if (mem_ack) begin
                        state_q <= cs_mem_release;
                        mem_req <= 1'b0;
                    end
                end
                cs_mem_release: begin
                    // wait for ack to fall before retiring
                    if (mem_done) begin
                        state_q       <= cs_idle;
                        retire        <= 1'b1;
                        // stores write no register
                        reg_write     <= !mem_write;
                        ld_commit_sel <= !mem_write;
                    end
                end
                cs_flush: begin
                    // redirect pulse is out, pointers rewind this cycle
                    state_q <= cs_idle;
                end
                default: state_q <= cs_idle;
            endcase
        end
    end

endmodule

/* verilog/rob_top.sv */
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_top (
    input  logic                  clk,
    input  logic                  rst,
    // allocate
    input  logic                  alloc_valid,
    input  rob_pkg::rob_op_t      alloc_op,
    input  logic [`REG_IDX_W-1:0] alloc_rd,
    input  logic                  alloc_pred_taken,
    output logic [`ROB_IDX_W-1:0] alloc_tag,
    output logic                  rob_full,
    // complete
    input  logic                  done_valid,
    input  logic [`ROB_IDX_W-1:0] done_tag,
    input  logic                  done_br_taken,
    // register commit
    output logic                  reg_write,
    output logic [`REG_IDX_W-1:0] commit_rd,
    output logic                  ld_commit_sel,
    // data cache
    output logic                  mem_req,
    output logic                  mem_write,
    output logic [`REG_IDX_W-1:0] mem_reg,
    input  logic                  mem_ack,
    // redirect
    output logic                  pc_redirect,
    output logic                  flush
);
    import rob_pkg::*;

    logic [`ROB_IDX_W-1:0] head_idx;
    logic                  alloc_we;
    logic                  retire;
    rob_op_t               head_op;
    logic [`REG_IDX_W-1:0] head_rd;
    logic                  head_done;
    logic                  head_mispredict;

    // head/tail pointers and occupancy
    // tail doubles as the tag of the next allocation
    rob_ptr_ctrl u_ptr_ctrl (
        .clk         (clk),
        .rst         (rst),
        .alloc_req   (alloc_valid),
        .retire      (retire),
        .flush_clear (flush),
        .head_idx    (head_idx),
        .tail_idx    (alloc_tag),
        .alloc_we    (alloc_we),
        .rob_full    (rob_full)
    );

    rob_entry_array u_entry_array (
        .clk              (clk),
        .rst              (rst),
        .alloc_we         (alloc_we),
        .alloc_idx        (alloc_tag),
        .alloc_op         (alloc_op),
        .alloc_rd         (alloc_rd),
        .alloc_pred_taken (alloc_pred_taken),
        .done_valid       (done_valid),
        .done_tag         (done_tag),
        .done_br_taken    (done_br_taken),
        .head_idx         (head_idx),
        .retire           (retire),
        .flush_clear      (flush),
        .head_op          (head_op),
        .head_rd          (head_rd),
        .head_done        (head_done),
        .head_mispredict  (head_mispredict)
    );

    // flush pulse goes out as-is and rewinds the pointers
    rob_commit_fsm u_commit_fsm (
        .clk             (clk),
        .rst             (rst),
        .head_op         (head_op),
        .head_rd         (head_rd),
        .head_done       (head_done),
        .head_mispredict (head_mispredict),
        .mem_ack         (mem_ack),
        .retire          (retire),
        .flush_clear     (flush),
        .reg_write       (reg_write),
        .commit_rd       (commit_rd),
        .ld_commit_sel   (ld_commit_sel),
        .mem_req         (mem_req),
        .mem_write       (mem_write),
        .mem_reg         (mem_reg),
        .pc_redirect     (pc_redirect)
    );

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for four rising edges, released just after the edge
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

/* tb/tb_rob_top.sv */
`timescale 1ns/1ps
`include "rob_macros.svh"

module tb_rob_top;
    import rob_pkg::*;

    typedef struct {
        int      grp;
        rob_op_t op;
        int      rd;
        bit      pred;
        bit      res;
        int      dly;
    } row_t;

    localparam int NROWS = 15;
    localparam int TMO   = 200;

    logic                  clk, rst;
    logic                  alloc_valid, alloc_pred_taken, done_valid, done_br_taken, mem_ack;
    rob_op_t               alloc_op;
    logic [`REG_IDX_W-1:0] alloc_rd, commit_rd, mem_reg;
    logic [`ROB_IDX_W-1:0] alloc_tag, done_tag;
    logic                  rob_full, reg_write, ld_commit_sel, mem_req, mem_write;
    logic                  pc_redirect, flush;

    row_t tbl [NROWS];
    int   seed = 32'had709b30;
    // expected register commits, in order
    int   exp_rd [$];
    bit   exp_ld [$];
    // expected cache requests, in order
    int   exp_mreg [$];
    bit   exp_mwr [$];
    int   redirect_cnt = 0;
    int   flush_cnt = 0;
    // mispredicted branches allocated so far
    int   exp_redirect_cnt = 0;
    int   exp_tail = 0;
    bit   hs_complete = 0;
    int   rsp_state = 0;
    int   rsp_wait = 0;
    int   rsp_tmo = 0;

    tb_clk_gen u_clk_gen (.clk(clk), .rst(rst));

    rob_top u_rob_top (
        .clk(clk), .rst(rst),
        .alloc_valid(alloc_valid), .alloc_op(alloc_op), .alloc_rd(alloc_rd),
        .alloc_pred_taken(alloc_pred_taken), .alloc_tag(alloc_tag), .rob_full(rob_full),
        .done_valid(done_valid), .done_tag(done_tag), .done_br_taken(done_br_taken),
        .reg_write(reg_write), .commit_rd(commit_rd), .ld_commit_sel(ld_commit_sel),
        .mem_req(mem_req), .mem_write(mem_write), .mem_reg(mem_reg), .mem_ack(mem_ack),
        .pc_redirect(pc_redirect), .flush(flush)
    );

    task automatic check_val(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("** Error at %0t: %s expected %0h got %0h", $time, name, exp, act);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Verification failed");
        $fatal(1, "timed out waiting for %s", what);
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic set_row(input int i, input int g, input rob_op_t op, input int rd,
                           input bit pred, input bit res, input int dly);
        tbl[i] = '{grp: g, op: op, rd: rd, pred: pred, res: res, dly: dly};
    endtask

    // group, op, register, predicted, resolved, completion delay
    task automatic init_table();
        set_row(0,  0, op_alu, 3,  0, 0, 0);
        set_row(1,  0, op_alu, 4,  0, 0, 1);
        set_row(2,  0, op_alu, 5,  0, 0, 0);
        set_row(3,  0, op_alu, 6,  0, 0, 2);
        set_row(4,  1, op_ld,  7,  0, 0, 1);
        set_row(5,  1, op_st,  8,  0, 0, 0);
        set_row(6,  1, op_alu, 9,  0, 0, 3);
        set_row(7,  1, op_ld,  10, 0, 0, 0);
        set_row(8,  2, op_alu, 11, 0, 0, 0);
        set_row(9,  2, op_br,  0,  1, 0, 2);
        set_row(10, 2, op_alu, 12, 0, 0, 0);
        set_row(11, 2, op_alu, 13, 0, 0, 1);
        set_row(12, 3, op_br,  0,  0, 0, 1);
        set_row(13, 3, op_alu, 14, 0, 0, 0);
        set_row(14, 3, op_alu, 15, 0, 0, 2);
    endtask

    // one allocation, waits out rob_full
    task automatic alloc_one(input rob_op_t op, input int rd, input bit pred);
        int t;
        t = 0;
        while (rob_full) begin
            @(posedge clk);
            #1;
            t++;
            if (t > TMO) fail_timeout("rob_full to drop");
        end
        check_val("alloc_tag", exp_tail, int'(alloc_tag));
        alloc_valid      = 1'b1;
        alloc_op         = op;
        alloc_rd         = 5'(rd);
        alloc_pred_taken = pred;
        @(posedge clk);
        #1;
        alloc_valid = 1'b0;
        exp_tail    = (exp_tail + 1) % `ROB_DEPTH;
    endtask

    task automatic complete_one(input int tag, input bit taken, input int dly);
        repeat (dly) begin
            @(posedge clk);
            #1;
        end
        done_valid    = 1'b1;
        done_tag      = 3'(tag);
        done_br_taken = taken;
        @(posedge clk);
        #1;
        done_valid = 1'b0;
    endtask

    task automatic wait_drained(input int exp_redirects);
        int t;
        t = 0;
        while (exp_rd.size() != 0 || exp_mreg.size() != 0 || redirect_cnt != exp_redirects
               || mem_req || mem_ack) begin
            @(posedge clk);
            #1;
            t++;
            if (t > TMO) fail_timeout("retirement to finish");
        end
        // quiet cycles, stray pulses are caught by the monitor
        repeat (4) @(posedge clk);
        #1;
        check_val("redirect count", exp_redirects, redirect_cnt);
        check_val("flush count", exp_redirects, flush_cnt);
    endtask

    // allocate a table group, complete it shuffled, wait for commits
    task automatic run_group(input int g);
        int idx [$];
        int tags [$];
        int ord [NROWS];
        int n, j, tmp, br_pos;
        bit flushed;
        int new_tail;
        flushed       = 0;
        br_pos        = -1;
        new_tail      = 0;
        for (int i = 0; i < NROWS; i++) begin
            if (tbl[i].grp == g) idx.push_back(i);
        end
        n = idx.size();
        for (int k = 0; k < n; k++) begin
            row_t r;
            r = tbl[idx[k]];
            tags.push_back(exp_tail);
            if (!flushed) begin
                if (r.op == op_alu || r.op == op_ld) begin
                    exp_rd.push_back(r.rd);
                    exp_ld.push_back(r.op == op_ld);
                end
                if (r.op == op_ld || r.op == op_st) begin
                    exp_mreg.push_back(r.rd);
                    exp_mwr.push_back(r.op == op_st);
                end
                if (r.op == op_br && r.pred != r.res) begin
                    flushed  = 1;
                    br_pos   = k;
                    new_tail = (exp_tail + 1) % `ROB_DEPTH;
                    exp_redirect_cnt++;
                end
            end
            alloc_one(r.op, r.rd, r.pred);
        end
        for (int k = 0; k < n; k++) ord[k] = k;
        for (int k = n - 1; k > 0; k--) begin
            j      = rand_below(k + 1);
            tmp    = ord[k];
            ord[k] = ord[j];
            ord[j] = tmp;
        end
        // mispredicted branch completes last, younger completions are then discarded
        if (br_pos >= 0) begin
            for (int k = 0; k < n; k++) begin
                if (ord[k] == br_pos) begin
                    ord[k]     = ord[n - 1];
                    ord[n - 1] = br_pos;
                end
            end
        end
        for (int k = 0; k < n; k++) begin
            complete_one(tags[ord[k]], tbl[idx[ord[k]]].res, tbl[idx[ord[k]]].dly);
        end
        wait_drained(exp_redirect_cnt);
        if (flushed) exp_tail = new_tail;
        check_val("rob_full", 0, int'(rob_full));
        check_val("alloc_tag", exp_tail, int'(alloc_tag));
    endtask

    // fill all eight entries, then probe the ignored ninth request
    task automatic fill_and_wrap();
        int ord [8];
        int j, tmp, t;
        for (int k = 0; k < 8; k++) begin
            exp_rd.push_back(k + 1);
            exp_ld.push_back(0);
            alloc_one(op_alu, k + 1, 0);
        end
        check_val("rob_full", 1, int'(rob_full));
        alloc_valid = 1'b1;
        alloc_op    = op_alu;
        alloc_rd    = 5'd31;
        @(posedge clk);
        #1;
        alloc_valid = 1'b0;
        check_val("alloc_tag", 0, int'(alloc_tag));
        complete_one(0, 0, 0);
        t = 0;
        while (exp_rd.size() != 7) begin
            @(posedge clk);
            #1;
            t++;
            if (t > TMO) fail_timeout("first retire of the full buffer");
        end
        @(posedge clk);
        #1;
        check_val("rob_full", 0, int'(rob_full));
        check_val("alloc_tag", 0, int'(alloc_tag));
        for (int k = 0; k < 7; k++) ord[k] = k + 1;
        for (int k = 6; k > 0; k--) begin
            j      = rand_below(k + 1);
            tmp    = ord[k];
            ord[k] = ord[j];
            ord[j] = tmp;
        end
        for (int k = 0; k < 7; k++) complete_one(ord[k], 0, rand_below(3));
        wait_drained(exp_redirect_cnt);
    endtask

    // commit monitor, outputs are registered so midcycle is stable
    always @(negedge clk) begin
        if (!rst) begin
            if (ld_commit_sel && !reg_write) check_val("reg_write", 1, 0);
            if (reg_write) begin
                if (exp_rd.size() == 0) begin
                    check_val("reg_write", 0, 1);
                end else begin
                    check_val("commit_rd", exp_rd.pop_front(), int'(commit_rd));
                    if (exp_ld.pop_front()) begin
                        check_val("ld_commit_sel", 1, int'(ld_commit_sel));
                        // four-phase exchange must be closed
                        check_val("handshake done", 1, int'(hs_complete));
                        hs_complete = 0;
                    end else begin
                        check_val("ld_commit_sel", 0, int'(ld_commit_sel));
                    end
                end
            end
            // one redirect and one flush per mispredicted branch
            if (pc_redirect) begin
                redirect_cnt++;
                if (redirect_cnt > exp_redirect_cnt) check_val("pc_redirect", 0, 1);
            end
            if (flush) begin
                flush_cnt++;
                if (flush_cnt > exp_redirect_cnt) check_val("flush", 0, 1);
            end
        end
    end

    // cache responder, 0 to 3 extra cycles per phase
    always @(posedge clk) begin
        #1;
        if (!rst) begin
            case (rsp_state)
                0: begin
                    if (mem_req) begin
                        if (exp_mreg.size() == 0) check_val("mem_req", 0, 1);
                        check_val("mem_write", int'(exp_mwr[0]), int'(mem_write));
                        check_val("mem_reg", exp_mreg[0], int'(mem_reg));
                        hs_complete = 0;
                        rsp_wait    = rand_below(4);
                        rsp_state   = 1;
                    end
                end
                1: begin
                    if (rsp_wait == 0) begin
                        mem_ack   = 1'b1;
                        rsp_tmo   = 0;
                        rsp_state = 2;
                    end else begin
                        rsp_wait--;
                    end
                end
                2: begin
                    if (mem_req) begin
                        // request fields held until release
                        check_val("mem_write", int'(exp_mwr[0]), int'(mem_write));
                        check_val("mem_reg", exp_mreg[0], int'(mem_reg));
                        rsp_tmo++;
                        if (rsp_tmo > TMO) fail_timeout("mem_req to drop");
                    end else begin
                        void'(exp_mreg.pop_front());
                        void'(exp_mwr.pop_front());
                        rsp_wait  = rand_below(4);
                        rsp_state = 3;
                    end
                end
                default: begin
                    if (rsp_wait == 0) begin
                        mem_ack     = 1'b0;
                        hs_complete = 1;
                        rsp_state   = 0;
                    end else begin
                        rsp_wait--;
                    end
                end
            endcase
        end
    end

    initial begin
        int t;
        alloc_valid      = 1'b0;
        alloc_op         = op_alu;
        alloc_rd         = '0;
        alloc_pred_taken = 1'b0;
        done_valid       = 1'b0;
        done_tag         = '0;
        done_br_taken    = 1'b0;
        mem_ack          = 1'b0;
        init_table();
        t = 0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
            t++;
            if (t > TMO) fail_timeout("reset release");
        end
        @(posedge clk);
        #1;
        check_val("reg_write", 0, int'(reg_write));
        check_val("pc_redirect", 0, int'(pc_redirect));
        check_val("flush", 0, int'(flush));
        check_val("mem_req", 0, int'(mem_req));
        check_val("ld_commit_sel", 0, int'(ld_commit_sel));
        check_val("rob_full", 0, int'(rob_full));
        fill_and_wrap();
        for (int g = 0; g < 4; g++) run_group(g);
        if (exp_rd.size() == 0 && exp_mreg.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "expected commits left over at end of run");
        end
    end

endmodule

/* rob_top.f */
+incdir+verilog
verilog/rob_pkg.sv
verilog/rob_ptr_ctrl.sv
verilog/rob_entry_array.sv
verilog/rob_commit_fsm.sv
verilog/rob_top.sv
tb/tb_clk_gen.sv
tb/tb_rob_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the ROB testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing \
    -f rob_top.f \
    --top-module tb_rob_top \
    -Mdir obj_dir \
    -o sim_rob

# exit status of the simulator decides pass or fail
./obj_dir/sim_rob

echo "simulation finished"
